// File: rtl/soc_periph_macros.svh
/*
  peripheral subsystem constants
  bus widths, GPIO width, slot map and register word indices
*/
`ifndef SOC_PERIPH_MACROS_SVH
`define SOC_PERIPH_MACROS_SVH

`define SP_ADDR_W       12
`define SP_DATA_W       32
`define SP_GPIO_W       12

// slot bases, each slot is 16 bytes wide
`define SP_GPIO_BASE    12'h000
`define SP_IRQ_BASE     12'h100
`define SP_SLOT_MASK    12'h00F

// irq pending layout, gpio edges in 11..0 and bus error above them
`define SP_IRQ_ERR_BIT  12
`define SP_IRQ_W        13

// word indices inside a slot (byte offset / 4)
`define SP_GPIO_REG_OUT 2'd0
`define SP_GPIO_REG_DIR 2'd1
`define SP_GPIO_REG_IN  2'd2
`define SP_IRQ_REG_PEND 2'd0
`define SP_IRQ_REG_ENA  2'd1

`endif

// File: rtl/soc_periph_pkg.sv
/*
  peripheral subsystem types
  bus opcodes, decoded slots and the request, access and response words
*/
`include "soc_periph_macros.svh"

package soc_periph_pkg;

  // single-beat bus opcode
  typedef enum logic
  {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  // decoded target of an access
  typedef enum logic [1:0]
  {
    SLOT_GPIO = 2'd0,
    SLOT_IRQ  = 2'd1,
    SLOT_NONE = 2'd2
  } slot_e;

  // request from the bus master
  typedef struct packed
  {
    bus_op_e               op;
    logic [`SP_ADDR_W-1:0] addr;
    logic [`SP_DATA_W-1:0] wdata;
  } bus_req_t;

  // access after address decode
  typedef struct packed
  {
    slot_e                 slot;
    bus_op_e               op;
    // word offset inside the slot
    logic [1:0]            reg_idx;
    logic [`SP_DATA_W-1:0] wdata;
  } slot_acc_t;

  // response toward the bus master
  typedef struct packed
  {
    logic [`SP_DATA_W-1:0] rdata;
    logic                  err;
  } bus_rsp_t;

endpackage

// File: rtl/bus_addr_decode.sv
/*
  bus address decode
  registers one request and maps its address to a peripheral slot
*/
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module bus_addr_decode
  import soc_periph_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_req_valid,
  output logic      o_req_ready,
  input  bus_req_t  i_req,
  output logic      o_acc_valid,
  input  logic      i_acc_ready,
  output slot_acc_t o_acc
);

  logic                  r_init;
  logic                  r_valid;
  slot_acc_t             r_acc;
  slot_acc_t             acc_nxt;
  logic [`SP_ADDR_W-1:0] slot_base;
  logic                  req_fire;

  //////////////////////////////////////////////////////////////////////
  // decode of the incoming address
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    // strip the in-slot offset to get the slot base
    slot_base       = i_req.addr & ~`SP_SLOT_MASK;
    acc_nxt.op      = i_req.op;
    acc_nxt.wdata   = i_req.wdata;
    // word index, byte bits 1..0 ignored
    acc_nxt.reg_idx = i_req.addr[3:2];
    if (slot_base == `SP_GPIO_BASE)
      acc_nxt.slot = SLOT_GPIO;
    else if (slot_base == `SP_IRQ_BASE)
      acc_nxt.slot = SLOT_IRQ;
    else
      acc_nxt.slot = SLOT_NONE;
  end

  // ready once out of reset, while empty or draining
  assign o_req_ready = r_init && (!r_valid || i_acc_ready);
  assign req_fire    = i_req_valid && o_req_ready;

  //////////////////////////////////////////////////////////////////////
  // one-entry decode register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_init  <= 1'b0;
      r_valid <= 1'b0;
    end
    else
    begin
      r_init <= 1'b1;
      if (req_fire)
        r_valid <= 1'b1;
      else if (i_acc_ready)
        r_valid <= 1'b0;
    end
  end

  // payload only, qualified by r_valid
  always_ff @(posedge i_clk)
  begin
    if (req_fire)
      r_acc <= acc_nxt;
  end

  assign o_acc_valid = r_valid;
  assign o_acc       = r_acc;

endmodule

// File: rtl/gpio_ctrl.sv
/*
  GPIO controller
  output and direction registers, synchronized inputs and
  rising-edge events for input pins
*/
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module gpio_ctrl
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_we,
  input  logic [1:0]            i_reg_idx,
  input  logic [`SP_DATA_W-1:0] i_wdata,
  output logic [`SP_DATA_W-1:0] o_rdata,
  input  logic [`SP_GPIO_W-1:0] i_gpio,
  output logic [`SP_GPIO_W-1:0] o_gpio,
  output logic [`SP_GPIO_W-1:0] o_gpio_dir,
  output logic [`SP_GPIO_W-1:0] o_edge_evt
);

  logic [`SP_GPIO_W-1:0] r_out;
  logic [`SP_GPIO_W-1:0] r_dir;
  // two-flop synchronizer, r_sync2 is the input register
  logic [`SP_GPIO_W-1:0] r_sync1;
  logic [`SP_GPIO_W-1:0] r_sync2;
  logic [`SP_GPIO_W-1:0] r_prev;
  logic [`SP_GPIO_W-1:0] r_edge;

  //////////////////////////////////////////////////////////////////////
  // bus writable registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_out <= '0;
      r_dir <= '0;
    end
    else if (i_we)
    begin
      // input and reserved offsets ignore writes
      if (i_reg_idx == `SP_GPIO_REG_OUT)
        r_out <= i_wdata[`SP_GPIO_W-1:0];
      else if (i_reg_idx == `SP_GPIO_REG_DIR)
        r_dir <= i_wdata[`SP_GPIO_W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // input path and edge detect
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_sync1 <= '0;
      r_sync2 <= '0;
      r_prev  <= '0;
      r_edge  <= '0;
    end
    else
    begin
      r_sync1 <= i_gpio;
      r_sync2 <= r_sync1;
      r_prev  <= r_sync2;
      // one-cycle pulse per rising bit, only for pins set as input
      r_edge  <= r_sync2 & ~r_prev & ~r_dir;
    end
  end

  // read mux, register values zero extended
  always_comb
  begin
    o_rdata = '0;
    case (i_reg_idx)
      `SP_GPIO_REG_OUT: o_rdata[`SP_GPIO_W-1:0] = r_out;
      `SP_GPIO_REG_DIR: o_rdata[`SP_GPIO_W-1:0] = r_dir;
      `SP_GPIO_REG_IN:  o_rdata[`SP_GPIO_W-1:0] = r_sync2;
      default:          o_rdata = '0;
    endcase
  end

  assign o_gpio     = r_out;
  assign o_gpio_dir = r_dir;
  assign o_edge_evt = r_edge;

endmodule

// File: rtl/irq_ctrl.sv
/*
  interrupt controller
  pending and enable bits for GPIO edges and bus errors, one irq output
*/
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module irq_ctrl
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_we,
  input  logic [1:0]            i_reg_idx,
  input  logic [`SP_DATA_W-1:0] i_wdata,
  output logic [`SP_DATA_W-1:0] o_rdata,
  input  logic [`SP_GPIO_W-1:0] i_edge_evt,
  input  logic                  i_err_evt,
  output logic                  o_irq
);

  logic [`SP_IRQ_W-1:0] r_pend;
  logic [`SP_IRQ_W-1:0] r_ena;
  logic [`SP_IRQ_W-1:0] set_vec;
  logic [`SP_IRQ_W-1:0] clr_vec;
  logic [`SP_IRQ_W-1:0] pend_nxt;
  logic [`SP_IRQ_W-1:0] ena_nxt;

  //////////////////////////////////////////////////////////////////////
  // next state of pending and enable
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    set_vec                       = '0;
    set_vec[`SP_GPIO_W-1:0]       = i_edge_evt;
    set_vec[`SP_IRQ_ERR_BIT]      = i_err_evt;
    // write-one-to-clear on the pending word
    clr_vec = '0;
    if (i_we && (i_reg_idx == `SP_IRQ_REG_PEND))
      clr_vec = i_wdata[`SP_IRQ_W-1:0];
    ena_nxt = r_ena;
    if (i_we && (i_reg_idx == `SP_IRQ_REG_ENA))
      ena_nxt = i_wdata[`SP_IRQ_W-1:0];
    // set beats clear in the same cycle
    pend_nxt = (r_pend & ~clr_vec) | set_vec;
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_pend <= '0;
      r_ena  <= '0;
      o_irq  <= 1'b0;
    end
    else
    begin
      r_pend <= pend_nxt;
      r_ena  <= ena_nxt;
      // irq follows pending in the same cycle
      o_irq  <= |(pend_nxt & ena_nxt);
    end
  end

  // read mux, offsets 8 and 12 read zero
  always_comb
  begin
    o_rdata = '0;
    case (i_reg_idx)
      `SP_IRQ_REG_PEND: o_rdata[`SP_IRQ_W-1:0] = r_pend;
      `SP_IRQ_REG_ENA:  o_rdata[`SP_IRQ_W-1:0] = r_ena;
      default:          o_rdata = '0;
    endcase
  end

endmodule

// File: rtl/bus_resp_mux.sv
/*
  response stage
  executes the decoded access on its slot and holds the response
  register until the master takes it
*/
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module bus_resp_mux
  import soc_periph_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_acc_valid,
  output logic                  o_acc_ready,
  input  slot_acc_t             i_acc,
  output logic                  o_gpio_we,
  output logic                  o_irq_we,
  output logic                  o_err_evt,
  output logic [1:0]            o_reg_idx,
  output logic [`SP_DATA_W-1:0] o_wdata,
  input  logic [`SP_DATA_W-1:0] i_gpio_rdata,
  input  logic [`SP_DATA_W-1:0] i_irq_rdata,
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  output bus_rsp_t              o_rsp
);

  logic     r_valid;
  bus_rsp_t r_rsp;
  bus_rsp_t rsp_nxt;
  logic     acc_fire;
  logic     is_wr;

  assign o_acc_ready = !r_valid || i_rsp_ready;
  assign acc_fire    = i_acc_valid && o_acc_ready;
  assign is_wr       = (i_acc.op == BUS_WRITE);

  // strobes fire only on the accepting edge
  assign o_gpio_we = acc_fire && is_wr && (i_acc.slot == SLOT_GPIO);
  assign o_irq_we  = acc_fire && is_wr && (i_acc.slot == SLOT_IRQ);
  assign o_err_evt = acc_fire && (i_acc.slot == SLOT_NONE);
  assign o_reg_idx = i_acc.reg_idx;
  assign o_wdata   = i_acc.wdata;

  //////////////////////////////////////////////////////////////////////
  // response word
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    rsp_nxt.err   = (i_acc.slot == SLOT_NONE);
    rsp_nxt.rdata = '0;
    // reads see register values before this edge's write
    if (!is_wr && (i_acc.slot == SLOT_GPIO))
      rsp_nxt.rdata = i_gpio_rdata;
    else if (!is_wr && (i_acc.slot == SLOT_IRQ))
      rsp_nxt.rdata = i_irq_rdata;
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      r_valid <= 1'b0;
    else if (acc_fire)
      r_valid <= 1'b1;
    else if (i_rsp_ready)
      r_valid <= 1'b0;
  end

  always_ff @(posedge i_clk)
  begin
    if (acc_fire)
      r_rsp <= rsp_nxt;
  end

  assign o_rsp_valid = r_valid;
  assign o_rsp       = r_rsp;

endmodule

// File: rtl/soc_periph_top.sv
/*
  peripheral subsystem top level
  address decode, GPIO and interrupt controllers, response stage
*/
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module soc_periph_top
  import soc_periph_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  // request channel
  input  logic                  i_req_valid,
  output logic                  o_req_ready,
  input  bus_req_t              i_req,
  // response channel
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  output bus_rsp_t              o_rsp,
  // pins
  input  logic [`SP_GPIO_W-1:0] i_gpio,
  output logic [`SP_GPIO_W-1:0] o_gpio,
  output logic [`SP_GPIO_W-1:0] o_gpio_dir,
  output logic                  o_irq
);

  logic                  w_acc_valid;
  logic                  w_acc_ready;
  slot_acc_t             w_acc;
  logic                  w_gpio_we;
  logic                  w_irq_we;
  logic                  w_err_evt;
  logic [1:0]            w_reg_idx;
  logic [`SP_DATA_W-1:0] w_wdata;
  logic [`SP_DATA_W-1:0] w_gpio_rdata;
  logic [`SP_DATA_W-1:0] w_irq_rdata;
  // gpio rising edges into the irq pending bits
  logic [`SP_GPIO_W-1:0] w_edge_evt;

  //////////////////////////////////////////////////////////////////////
  // decode stage
  //////////////////////////////////////////////////////////////////////
  bus_addr_decode dec0 (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req       (i_req),
    .o_acc_valid (w_acc_valid),
    .i_acc_ready (w_acc_ready),
    .o_acc       (w_acc)
  );

  //////////////////////////////////////////////////////////////////////
  // peripherals
  //////////////////////////////////////////////////////////////////////
  gpio_ctrl gpio0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_we       (w_gpio_we),
    .i_reg_idx  (w_reg_idx),
    .i_wdata    (w_wdata),
    .o_rdata    (w_gpio_rdata),
    .i_gpio     (i_gpio),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir),
    .o_edge_evt (w_edge_evt)
  );

  irq_ctrl irq0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_we       (w_irq_we),
    .i_reg_idx  (w_reg_idx),
    .i_wdata    (w_wdata),
    .o_rdata    (w_irq_rdata),
    .i_edge_evt (w_edge_evt),
    .i_err_evt  (w_err_evt),
    .o_irq      (o_irq)
  );

  // response stage, also the execute strobes
  bus_resp_mux rsp0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_acc_valid  (w_acc_valid),
    .o_acc_ready  (w_acc_ready),
    .i_acc        (w_acc),
    .o_gpio_we    (w_gpio_we),
    .o_irq_we     (w_irq_we),
    .o_err_evt    (w_err_evt),
    .o_reg_idx    (w_reg_idx),
    .o_wdata      (w_wdata),
    .i_gpio_rdata (w_gpio_rdata),
    .i_irq_rdata  (w_irq_rdata),
    .o_rsp_valid  (o_rsp_valid),
    .i_rsp_ready  (i_rsp_ready),
    .o_rsp        (o_rsp)
  );

endmodule

// File: sim/soc_periph_sva.sv
/*
  response stage checks
  handshake stability, reset state and one-hot execute strobes
*/
`timescale 1ns/1ps

module soc_periph_sva
  import soc_periph_pkg::*;
(
  input logic      i_clk,
  input logic      i_rst_n,
  input logic      i_acc_valid,
  input logic      i_acc_ready,
  input slot_acc_t i_acc,
  input logic      i_gpio_we,
  input logic      i_irq_we,
  input logic      i_err_evt,
  input logic      i_rsp_valid,
  input logic      i_rsp_ready,
  input bus_rsp_t  i_rsp
);

  // decode stage holds its access while stalled
  acc_hold_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_acc_valid && !i_acc_ready) |=> (i_acc_valid && $stable(i_acc)))
    else $error("access payload changed while stalled");

  // response held under back-pressure
  rsp_hold_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp)))
    else $error("response payload changed while stalled");

  // valid stays low after reset until an access is accepted
  rst_exit_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_rsp_valid) |-> $past(i_acc_valid && i_acc_ready))
    else $error("response valid without an accepted access");

  // an accepted write or unmapped access acts on exactly one slot
  strobe_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_acc_valid && i_acc_ready && ((i_acc.op == BUS_WRITE) || (i_acc.slot == SLOT_NONE)))
      |-> $onehot({i_gpio_we, i_irq_we, i_err_evt}))
    else $error("execute strobes not one-hot for an accepted access");

endmodule

bind bus_resp_mux soc_periph_sva sva_i (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_acc_valid (i_acc_valid),
  .i_acc_ready (o_acc_ready),
  .i_acc       (i_acc),
  .i_gpio_we   (o_gpio_we),
  .i_irq_we    (o_irq_we),
  .i_err_evt   (o_err_evt),
  .i_rsp_valid (o_rsp_valid),
  .i_rsp_ready (i_rsp_ready),
  .i_rsp       (o_rsp)
);

// File: sim/soc_periph_tb.sv
/*
  testbench for the peripheral subsystem
  replays the golden transactions under random response back-pressure
  and checks responses and pins in request order
*/
`timescale 1ns/1ps
`include "soc_periph_macros.svh"

module soc_periph_tb
  import soc_periph_pkg::*;
();

  localparam int rst_cycles      = 16;
  localparam int cycles_per_line = 20;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_req_valid;
  logic                  o_req_ready;
  bus_req_t              i_req;
  logic                  o_rsp_valid;
  logic                  i_rsp_ready;
  bus_rsp_t              o_rsp;
  logic [`SP_GPIO_W-1:0] i_gpio;
  logic [`SP_GPIO_W-1:0] o_gpio;
  logic [`SP_GPIO_W-1:0] o_gpio_dir;
  logic                  o_irq;

  // golden vectors with one entry per file line
  string                 gv_name[$];
  bus_req_t              gv_req[$];
  logic [`SP_GPIO_W-1:0] gv_gpio[$];
  int                    gv_gap[$];
  bus_rsp_t              gv_rsp[$];
  logic [`SP_GPIO_W-1:0] gv_out[$];
  logic [`SP_GPIO_W-1:0] gv_dir[$];
  logic                  gv_irq[$];
  // golden index of each request in flight with the oldest first
  int                    exp_idx_q[$];
  int                    rsp_idx;
  integer                seed = 46222;
  int                    cycle_count = 0;
  int                    cycle_limit = 0;

  soc_periph_top dut_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req       (i_req),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp       (o_rsp),
    .i_gpio      (i_gpio),
    .o_gpio      (o_gpio),
    .o_gpio_dir  (o_gpio_dir),
    .o_irq       (o_irq)
  );

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////
  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp_rsp,
                           input bus_rsp_t act_rsp);
    if (act_rsp !== exp_rsp)
    begin
      $display("MISMATCH %s response expected rdata=%h err=%b actual rdata=%h err=%b",
               name, exp_rsp.rdata, exp_rsp.err, act_rsp.rdata, act_rsp.err);
      stop_on_error();
    end
  endtask

  task automatic check_pins(input string name, input logic [`SP_GPIO_W-1:0] exp_gpio,
                            input logic [`SP_GPIO_W-1:0] exp_dir, input logic exp_irq);
    if ((o_gpio !== exp_gpio) || (o_gpio_dir !== exp_dir) || (o_irq !== exp_irq))
    begin
      $display("MISMATCH %s pins expected gpio=%h dir=%h irq=%b actual gpio=%h dir=%h irq=%b",
               name, exp_gpio, exp_dir, exp_irq, o_gpio, o_gpio_dir, o_irq);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // golden file
  //////////////////////////////////////////////////////////////////////
  task automatic load_golden();
    integer            fd;
    integer            got;
    integer            n;
    integer            t_gap;
    string             name;
    logic [31:0]       t_op;
    logic [31:0]       t_addr;
    logic [31:0]       t_wdata;
    logic [31:0]       t_gpio;
    logic [31:0]       t_rdata;
    logic [31:0]       t_err;
    logic [31:0]       t_out;
    logic [31:0]       t_dir;
    logic [31:0]       t_irq;
    logic [8*160-1:0]  line_buf;
    bus_req_t          req;
    bus_rsp_t          rsp;
    fd = $fopen("sim/soc_periph_golden.txt", "r");
    if (fd == 0)
    begin
      $display("error: cannot open the golden file");
      stop_on_error();
    end
    while (!$feof(fd))
    begin
      got = $fgets(line_buf, fd);
      n = $sscanf(line_buf, "%s %h %h %h %h %d %h %h %h %h %h", name, t_op, t_addr,
                  t_wdata, t_gpio, t_gap, t_rdata, t_err, t_out, t_dir, t_irq);
      // comment and blank lines never parse to all eleven columns
      if ((got != 0) && (n == 11))
      begin
        req.op    = bus_op_e'(t_op[0]);
        req.addr  = t_addr[`SP_ADDR_W-1:0];
        req.wdata = t_wdata;
        rsp.rdata = t_rdata;
        rsp.err   = t_err[0];
        gv_name.push_back(name);
        gv_req.push_back(req);
        gv_gpio.push_back(t_gpio[`SP_GPIO_W-1:0]);
        gv_gap.push_back(t_gap);
        gv_rsp.push_back(rsp);
        gv_out.push_back(t_out[`SP_GPIO_W-1:0]);
        gv_dir.push_back(t_dir[`SP_GPIO_W-1:0]);
        gv_irq.push_back(t_irq[0]);
      end
    end
    $fclose(fd);
    if (gv_name.size() == 0)
    begin
      $display("error: the golden file holds no transactions");
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // request issuer
  //////////////////////////////////////////////////////////////////////
  task automatic send_requests();
    for (int i = 0; i < gv_name.size(); i++)
    begin
      if (gv_gap[i] != 0)
      begin
        // drain first so pin events land between accesses
        i_req_valid <= 1'b0;
        while (exp_idx_q.size() != 0)
          @(posedge i_clk);
        i_gpio <= gv_gpio[i];
        repeat (gv_gap[i]) @(posedge i_clk);
      end
      i_req_valid <= 1'b1;
      i_req       <= gv_req[i];
      exp_idx_q.push_back(i);
      // ready seen at negedge means a transfer on the next rising edge
      do
        @(negedge i_clk);
      while (!o_req_ready);
      @(posedge i_clk);
    end
    i_req_valid <= 1'b0;
  endtask

  initial
  begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // response back-pressure with ready about three cycles in four
  initial
  begin
    i_rsp_ready = 1'b0;
    wait (i_rst_n);
    forever
    begin
      @(posedge i_clk);
      i_rsp_ready <= (($random(seed) & 3) != 0);
    end
  end

  // response checker sampling at negedge where outputs are settled
  initial
  begin
    forever
    begin
      @(negedge i_clk);
      if (i_rst_n && o_rsp_valid && i_rsp_ready)
      begin
        if (exp_idx_q.size() == 0)
        begin
          $display("error: a response arrived with no request outstanding");
          stop_on_error();
        end
        else
        begin
          rsp_idx = exp_idx_q.pop_front();
          check_rsp(gv_name[rsp_idx], gv_rsp[rsp_idx], o_rsp);
          check_pins(gv_name[rsp_idx], gv_out[rsp_idx], gv_dir[rsp_idx], gv_irq[rsp_idx]);
        end
      end
    end
  end

  // run limit grows with the number of golden lines
  initial
  begin
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit)
    begin
      @(posedge i_clk);
      cycle_count = cycle_count + 1;
    end
    $display("error: test did not finish within %0d clock cycles", cycle_limit);
    $display("TB FAILED");
    $fatal(1, "simulation timed out");
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req       = '0;
    i_gpio      = '0;
    load_golden();
    cycle_limit = cycles_per_line * gv_name.size() + rst_cycles;
    repeat (rst_cycles / 2) @(posedge i_clk);
    // reset state checked halfway through reset
    @(negedge i_clk);
    check_pins("reset", '0, '0, 1'b0);
    if (o_req_ready || o_rsp_valid)
    begin
      $display("error: request ready or response valid high during reset");
      stop_on_error();
    end
    repeat (rst_cycles / 2) @(posedge i_clk);
    i_rst_n <= 1'b1;
    send_requests();
    while (exp_idx_q.size() != 0)
      @(posedge i_clk);
    // idle tail catches a duplicated response
    repeat (4) @(posedge i_clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: sim/soc_periph_golden.txt
# name op addr wdata gpio gap | expected rdata err out dir irq (hex, gap decimal)
# gpio is applied before an idle gap of gap cycles, pins are checked with each response
gpio_out_wr    1 000 00000a5c 000 0 00000000 0 a5c 000 0
gpio_out_rd    0 000 00000000 000 0 00000a5c 0 a5c 000 0
gpio_dir_wr    1 004 00000f0f 000 0 00000000 0 a5c f0f 0
gpio_dir_rd    0 004 00000000 000 0 00000f0f 0 a5c f0f 0
gpio_out_wide  1 000 ffffffff 000 0 00000000 0 fff f0f 0
gpio_out_rd2   0 000 00000000 000 0 00000fff 0 fff f0f 0
gpio_rsvd_rd   0 00c 00000000 000 0 00000000 0 fff f0f 0
gpio_in_wr     1 008 12345678 000 0 00000000 0 fff f0f 0
gpio_in_rd0    0 008 00000000 000 0 00000000 0 fff f0f 0
gpio_in_rd1    0 008 00000000 3a5 8 000003a5 0 fff f0f 0
irq_pend_rd    0 100 00000000 3a5 0 000000a0 0 fff f0f 0
irq_ena_wr     1 104 00000020 3a5 0 00000000 0 fff f0f 1
irq_ena_rd     0 104 00000000 3a5 0 00000020 0 fff f0f 1
irq_clr_wr     1 100 00000020 3a5 0 00000000 0 fff f0f 0
irq_pend_rd2   0 100 00000000 3a5 0 00000080 0 fff f0f 0
irq_rsvd_rd    0 108 00000000 3a5 0 00000000 0 fff f0f 0
irq_rsvd_rd2   0 10c 00000000 3a5 0 00000000 0 fff f0f 0
unmapped_rd    0 200 00000000 3a5 0 00000000 1 fff f0f 0
unmapped_wr    1 ff4 deadbeef 3a5 0 00000000 1 fff f0f 0
irq_pend_rd3   0 100 00000000 3a5 0 00001080 0 fff f0f 0
irq_ena_wr2    1 104 00001000 3a5 0 00000000 0 fff f0f 1
irq_clr_wr2    1 100 00001080 3a5 0 00000000 0 fff f0f 0
irq_pend_rd4   0 100 00000000 3a5 0 00000000 0 fff f0f 0
gpio_in_rd2    0 008 00000000 f5a 8 00000f5a 0 fff f0f 0
irq_pend_rd5   0 100 00000000 f5a 0 00000050 0 fff f0f 0
irq_ena_byte   0 106 00000000 f5a 0 00001000 0 fff f0f 0
irq_ena_wr3    1 104 00000010 f5a 0 00000000 0 fff f0f 1
irq_clr_wr3    1 100 00000050 f5a 0 00000000 0 fff f0f 0
gpio_dir_wr2   1 004 00000000 f5a 0 00000000 0 fff 000 0
unmapped_rd2   0 0f0 00000000 f5a 0 00000000 1 fff 000 0
irq_pend_rd6   0 100 00000000 f5a 0 00001000 0 fff 000 0

// File: all.f
+incdir+rtl
rtl/soc_periph_pkg.sv
rtl/bus_addr_decode.sv
rtl/gpio_ctrl.sv
rtl/irq_ctrl.sv
rtl/bus_resp_mux.sv
rtl/soc_periph_top.sv
sim/soc_periph_sva.sv
sim/soc_periph_tb.sv

// File: Makefile
# Verilator build and run of the peripheral subsystem testbench

SIM := obj_dir/soc_periph_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -f sim.log
	verilator --binary --timing --assert -j 0 --top-module soc_periph_tb \
		-f all.f -o soc_periph_sim
	./$(SIM) | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
